/* hdl/ps2_pkg.sv */
`default_nettype none

package ps2_pkg;

    // host register port widths.
    localparam int reg_data_w = 16;
    localparam int timeout_w  = 16;

    // scan code set 2 prefix bytes.
    localparam logic [7:0] ps2_extended_code = 8'hE0;
    localparam logic [7:0] ps2_release_code  = 8'hF0;

    // register map.
    // ctrl     bit 0 enables the receiver.
    // timeout  idle cycles allowed inside a frame.
    // errors   parity count low byte, framing count high byte.
    // overflow dropped event count low byte.
    typedef enum logic [1:0] {
        addr_ctrl     = 2'd0,
        addr_timeout  = 2'd1,
        addr_errors   = 2'd2,
        addr_overflow = 2'd3
    } reg_addr_t;

    // one decoded key event.
    typedef struct packed {
        logic [7:0] scan;
        logic       extended;
        logic       released;
    } key_event_t;

endpackage

`default_nettype wire

/* hdl/ps2_byte_if.sv */
`timescale 1ns/1ps
`default_nettype none

interface ps2_byte_if;

    logic       valid;
    logic [7:0] data;
    logic       parity_err;
    logic       frame_err;

    modport tx (
        output valid,
        output data,
        output parity_err,
        output frame_err
    );

    modport rx (
        input valid,
        input data,
        input parity_err,
        input frame_err
    );

    // error monitor only needs the flags.
    modport mon (
        input valid,
        input parity_err,
        input frame_err
    );

endinterface

`default_nettype wire

/* hdl/ps2_frame_rx.sv */
`timescale 1ns/1ps
`default_nettype none

module ps2_frame_rx
    import ps2_pkg::*;
(
    input  logic                 CLK,
    input  logic                 RESET_N,
    input  logic                 ps2_clk,
    input  logic                 ps2_data,
    input  logic                 enable,
    input  logic [timeout_w-1:0] timeout_cycles,
    ps2_byte_if.tx               byte_out
);

    logic [1:0]           clk_sync;
    logic [1:0]           data_sync;
    logic                 clk_prev;
    logic                 clk_fall;
    logic [9:0]           shreg;
    logic [3:0]           bit_cnt;
    logic [timeout_w-1:0] idle_cnt;
    logic                 in_frame;
    logic                 last_bit;
    logic                 timed_out;
    logic                 parity_ok;
    logic                 framing_ok;

    // both lines idle high.
    always_ff @(posedge CLK or negedge RESET_N) begin
        if (!RESET_N) begin
            clk_sync  <= 2'b11;
            data_sync <= 2'b11;
            clk_prev  <= 1'b1;
        end else begin
            clk_sync  <= {clk_sync[0], ps2_clk};
            data_sync <= {data_sync[0], ps2_data};
            clk_prev  <= clk_sync[1];
        end
    end

    assign clk_fall = clk_prev & ~clk_sync[1];

    assign in_frame  = (bit_cnt != 4'd0);
    assign last_bit  = (bit_cnt == 4'd10);
    assign timed_out = in_frame && !clk_fall && (idle_cnt == timeout_cycles);

    // shreg holds start, data and parity once the stop bit arrives.
    assign parity_ok  = ^shreg[9:1];
    assign framing_ok = !shreg[0] && data_sync[1];

    always_ff @(posedge CLK or negedge RESET_N) begin
        if (!RESET_N) begin
            bit_cnt        <= 4'd0;
            idle_cnt       <= '0;
            byte_out.valid <= 1'b0;
        end else begin
            byte_out.valid <= 1'b0;
            if (!enable) begin
                bit_cnt  <= 4'd0;
                idle_cnt <= '0;
            end else if (clk_fall) begin
                idle_cnt <= '0;
                if (last_bit) begin
                    bit_cnt        <= 4'd0;
                    byte_out.valid <= 1'b1;
                end else begin
                    bit_cnt <= bit_cnt + 4'd1;
                end
            end else if (timed_out) begin
                // keyboard stalled mid frame.
                bit_cnt        <= 4'd0;
                idle_cnt       <= '0;
                byte_out.valid <= 1'b1;
            end else if (in_frame) begin
                idle_cnt <= idle_cnt + 1'b1;
            end
        end
    end

    always_ff @(posedge CLK) begin
        if (clk_fall) begin
            shreg <= {data_sync[1], shreg[9:1]};
        end
        if (enable && clk_fall && last_bit) begin
            byte_out.data       <= shreg[8:1];
            byte_out.parity_err <= !parity_ok;
            byte_out.frame_err  <= !framing_ok;
        end else if (enable && timed_out) begin
            byte_out.data       <= 8'h00;
            byte_out.parity_err <= 1'b0;
            byte_out.frame_err  <= 1'b1;
        end
    end

    // frames are far longer than one cycle apart.
    a_single_pulse: assert property (
        @(posedge CLK) disable iff (!RESET_N)
        byte_out.valid |=> !byte_out.valid
    ) else $error("byte valid held for two cycles");

endmodule

`default_nettype wire

/* hdl/ps2_code_decoder.sv */
`timescale 1ns/1ps
`default_nettype none

module ps2_code_decoder
    import ps2_pkg::*;
(
    input  logic       CLK,
    input  logic       RESET_N,
    ps2_byte_if.rx     byte_in,
    output logic       event_valid,
    output key_event_t event_data
);

    logic ext_pending;
    logic rel_pending;
    logic byte_clean;
    logic is_prefix;

    assign byte_clean = byte_in.valid && !byte_in.parity_err && !byte_in.frame_err;
    assign is_prefix  = (byte_in.data == ps2_extended_code) ||
                        (byte_in.data == ps2_release_code);

    always_ff @(posedge CLK or negedge RESET_N) begin
        if (!RESET_N) begin
            ext_pending <= 1'b0;
            rel_pending <= 1'b0;
            event_valid <= 1'b0;
        end else begin
            event_valid <= 1'b0;
            if (byte_in.valid && !byte_clean) begin
                // a broken byte kills any half-built sequence.
                ext_pending <= 1'b0;
                rel_pending <= 1'b0;
            end else if (byte_clean) begin
                if (byte_in.data == ps2_extended_code) begin
                    ext_pending <= 1'b1;
                end else if (byte_in.data == ps2_release_code) begin
                    rel_pending <= 1'b1;
                end else begin
                    event_valid <= 1'b1;
                    ext_pending <= 1'b0;
                    rel_pending <= 1'b0;
                end
            end
        end
    end

    always_ff @(posedge CLK) begin
        if (byte_clean && !is_prefix) begin
            event_data.scan     <= byte_in.data;
            event_data.extended <= ext_pending;
            event_data.released <= rel_pending;
        end
    end

endmodule

`default_nettype wire

/* hdl/key_event_fifo.sv */
`timescale 1ns/1ps
`default_nettype none

module key_event_fifo
    import ps2_pkg::*;
#(
    parameter int fifo_depth = 4
) (
    input  logic       CLK,
    input  logic       RESET_N,
    input  logic       in_valid,
    input  key_event_t in_data,
    output logic       out_valid,
    input  logic       out_ready,
    output key_event_t out_data,
    output logic       overflow
);

    localparam int ptr_w = $clog2(fifo_depth);
    localparam int cnt_w = $clog2(fifo_depth + 1);

    key_event_t           mem [fifo_depth];
    logic [ptr_w-1:0]     wr_ptr;
    logic [ptr_w-1:0]     rd_ptr;
    logic [cnt_w-1:0]     count;
    logic                 full;
    logic                 push;
    logic                 pop;

    assign full      = (count == cnt_w'(fifo_depth));
    assign out_valid = (count != '0);
    assign out_data  = mem[rd_ptr];
    assign pop       = out_valid && out_ready;
    // a slot freed this cycle can be refilled at once.
    assign push      = in_valid && (!full || pop);

    always_ff @(posedge CLK or negedge RESET_N) begin
        if (!RESET_N) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            count    <= '0;
            overflow <= 1'b0;
        end else begin
            overflow <= in_valid && !push;
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            if (push && !pop) begin
                count <= count + 1'b1;
            end else if (pop && !push) begin
                count <= count - 1'b1;
            end
        end
    end

    always_ff @(posedge CLK) begin
        if (push) begin
            mem[wr_ptr] <= in_data;
        end
    end

    a_hold_stable: assert property (
        @(posedge CLK) disable iff (!RESET_N)
        out_valid && !out_ready |=> out_valid && $stable(out_data)
    ) else $error("event changed while stalled");

    a_count_bound: assert property (
        @(posedge CLK) disable iff (!RESET_N)
        count <= cnt_w'(fifo_depth)
    ) else $error("fifo count above depth");

endmodule

`default_nettype wire

/* hdl/ps2_ctrl_regs.sv */
`timescale 1ns/1ps
`default_nettype none

module ps2_ctrl_regs
    import ps2_pkg::*;
#(
    parameter int timeout_reset = 1000
) (
    input  logic                  CLK,
    input  logic                  RESET_N,
    input  reg_addr_t             reg_addr,
    input  logic [reg_data_w-1:0] reg_wdata,
    input  logic                  reg_write,
    output logic [reg_data_w-1:0] reg_rdata,
    ps2_byte_if.mon               byte_mon,
    input  logic                  overflow,
    output logic                  enable,
    output logic [timeout_w-1:0]  timeout_cycles
);

    logic [7:0] par_cnt;
    logic [7:0] frm_cnt;
    logic [7:0] ovf_cnt;
    logic       clr_errors;
    logic       clr_overflow;

    assign clr_errors   = reg_write && (reg_addr == addr_errors);
    assign clr_overflow = reg_write && (reg_addr == addr_overflow);

    always_ff @(posedge CLK or negedge RESET_N) begin
        if (!RESET_N) begin
            enable         <= 1'b1;
            timeout_cycles <= timeout_w'(timeout_reset);
            par_cnt        <= 8'd0;
            frm_cnt        <= 8'd0;
            ovf_cnt        <= 8'd0;
        end else begin
            if (reg_write && reg_addr == addr_ctrl) begin
                enable <= reg_wdata[0];
            end
            if (reg_write && reg_addr == addr_timeout) begin
                timeout_cycles <= reg_wdata[timeout_w-1:0];
            end
            // counters stick at 255.
            if (clr_errors) begin
                par_cnt <= 8'd0;
                frm_cnt <= 8'd0;
            end else if (byte_mon.valid) begin
                if (byte_mon.parity_err && par_cnt != 8'hFF) begin
                    par_cnt <= par_cnt + 8'd1;
                end
                if (byte_mon.frame_err && frm_cnt != 8'hFF) begin
                    frm_cnt <= frm_cnt + 8'd1;
                end
            end
            if (clr_overflow) begin
                ovf_cnt <= 8'd0;
            end else if (overflow && ovf_cnt != 8'hFF) begin
                ovf_cnt <= ovf_cnt + 8'd1;
            end
        end
    end

    always_comb begin
        case (reg_addr)
            addr_ctrl:     reg_rdata = {{(reg_data_w - 1){1'b0}}, enable};
            addr_timeout:  reg_rdata = reg_data_w'(timeout_cycles);
            addr_errors:   reg_rdata = {frm_cnt, par_cnt};
            addr_overflow: reg_rdata = {8'd0, ovf_cnt};
            default:       reg_rdata = '0;
        endcase
    end

    // zero would make the receiver drop every frame.
    a_timeout_nonzero: assert property (
        @(posedge CLK) disable iff (!RESET_N)
        reg_write && reg_addr == addr_timeout |-> reg_wdata[timeout_w-1:0] != '0
    ) else $error("timeout register written with zero");

endmodule

`default_nettype wire

/* hdl/ps2_keyboard_top.sv */
`timescale 1ns/1ps
`default_nettype none

module ps2_keyboard_top
    import ps2_pkg::*;
#(
    parameter int fifo_depth    = 4,
    parameter int timeout_reset = 1000
) (
    input  logic                  CLK,
    input  logic                  RESET_N,
    input  logic                  ps2_clk,
    input  logic                  ps2_data,
    input  reg_addr_t             reg_addr,
    input  logic [reg_data_w-1:0] reg_wdata,
    input  logic                  reg_write,
    output logic [reg_data_w-1:0] reg_rdata,
    output logic                  event_valid,
    input  logic                  event_ready,
    output logic [7:0]            event_scan,
    output logic                  event_extended,
    output logic                  event_released
);

    ps2_byte_if byte_if0 ();

    logic                 enable;
    logic [timeout_w-1:0] timeout_cycles;
    logic                 dec_valid;
    key_event_t           dec_event;
    key_event_t           fifo_event;
    logic                 overflow;

    ps2_frame_rx frame_rx0 (
        .CLK            (CLK),
        .RESET_N        (RESET_N),
        .ps2_clk        (ps2_clk),
        .ps2_data       (ps2_data),
        .enable         (enable),
        .timeout_cycles (timeout_cycles),
        .byte_out       (byte_if0.tx)
    );

    ps2_code_decoder decoder0 (
        .CLK         (CLK),
        .RESET_N     (RESET_N),
        .byte_in     (byte_if0.rx),
        .event_valid (dec_valid),
        .event_data  (dec_event)
    );

    key_event_fifo #(
        .fifo_depth (fifo_depth)
    ) fifo0 (
        .CLK       (CLK),
        .RESET_N   (RESET_N),
        .in_valid  (dec_valid),
        .in_data   (dec_event),
        .out_valid (event_valid),
        .out_ready (event_ready),
        .out_data  (fifo_event),
        .overflow  (overflow)
    );

    ps2_ctrl_regs #(
        .timeout_reset (timeout_reset)
    ) regs0 (
        .CLK            (CLK),
        .RESET_N        (RESET_N),
        .reg_addr       (reg_addr),
        .reg_wdata      (reg_wdata),
        .reg_write      (reg_write),
        .reg_rdata      (reg_rdata),
        .byte_mon       (byte_if0.mon),
        .overflow       (overflow),
        .enable         (enable),
        .timeout_cycles (timeout_cycles)
    );

    assign event_scan     = fifo_event.scan;
    assign event_extended = fifo_event.extended;
    assign event_released = fifo_event.released;

endmodule

`default_nettype wire

/* tests/tb_ps2_keyboard.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_ps2_keyboard
    import ps2_pkg::*;
();

    localparam int fifo_depth    = 4;
    localparam int timeout_reset = 1000;
    localparam int half_bit      = 10;
    localparam int stall_cycles  = timeout_reset + 100;
    localparam int frame_count   = 30;
    // frames x bits x cycles per bit x clock period, plus slack.
    localparam int watchdog_ns   = frame_count * 11 * 20 * 4 + 20000;

    logic                  CLK;
    logic                  RESET_N;
    logic                  ps2_clk;
    logic                  ps2_data;
    reg_addr_t             reg_addr;
    logic [reg_data_w-1:0] reg_wdata;
    logic                  reg_write;
    logic [reg_data_w-1:0] reg_rdata;
    logic                  event_valid;
    logic                  event_ready;
    logic [7:0]            event_scan;
    logic                  event_extended;
    logic                  event_released;

    int         seed = 47;
    int         err_count = 0;
    int         test_count = 0;
    int         fail_count = 0;
    logic       ext_pend = 1'b0;
    logic       rel_pend = 1'b0;
    key_event_t got_q[$];
    key_event_t exp_q[$];

    ps2_keyboard_top #(
        .fifo_depth    (fifo_depth),
        .timeout_reset (timeout_reset)
    ) dut0 (
        .CLK            (CLK),
        .RESET_N        (RESET_N),
        .ps2_clk        (ps2_clk),
        .ps2_data       (ps2_data),
        .reg_addr       (reg_addr),
        .reg_wdata      (reg_wdata),
        .reg_write      (reg_write),
        .reg_rdata      (reg_rdata),
        .event_valid    (event_valid),
        .event_ready    (event_ready),
        .event_scan     (event_scan),
        .event_extended (event_extended),
        .event_released (event_released)
    );

    always #2 CLK = ~CLK;

    // a transfer happens on the next rising edge.
    always @(negedge CLK) begin
        key_event_t ev;
        if (RESET_N && event_valid && event_ready) begin
            ev.scan     = event_scan;
            ev.extended = event_extended;
            ev.released = event_released;
            got_q.push_back(ev);
        end
    end

    task automatic compare_event(input string what, input key_event_t got,
                                 input key_event_t exp);
        if (got !== exp) begin
            $display("MISMATCH at %0t: %s event scan %h ext %b rel %b, expected %h %b %b",
                     $time, what, got.scan, got.extended, got.released,
                     exp.scan, exp.extended, exp.released);
            err_count++;
        end
    endtask

    task automatic compare_reg(input string what, input logic [reg_data_w-1:0] got,
                               input logic [reg_data_w-1:0] exp);
        if (got !== exp) begin
            $display("MISMATCH at %0t: %s reads %h, expected %h", $time, what, got, exp);
            err_count++;
        end
    endtask

    task automatic write_reg(input reg_addr_t addr, input logic [reg_data_w-1:0] data);
        @(posedge CLK);
        reg_addr  <= addr;
        reg_wdata <= data;
        reg_write <= 1'b1;
        @(posedge CLK);
        reg_write <= 1'b0;
    endtask

    task automatic read_reg(input reg_addr_t addr, output logic [reg_data_w-1:0] data);
        @(posedge CLK);
        reg_addr <= addr;
        @(negedge CLK);
        data = reg_rdata;
    endtask

    // reference for the prefix rule.
    task automatic model_byte(input logic [7:0] code, input bit clean);
        key_event_t ev;
        if (!clean) begin
            ext_pend = 1'b0;
            rel_pend = 1'b0;
        end else if (code == ps2_extended_code) begin
            ext_pend = 1'b1;
        end else if (code == ps2_release_code) begin
            rel_pend = 1'b1;
        end else begin
            ev.scan     = code;
            ev.extended = ext_pend;
            ev.released = rel_pend;
            exp_q.push_back(ev);
            ext_pend = 1'b0;
            rel_pend = 1'b0;
        end
    endtask

    // keyboard side, start bit first and data lsb first.
    task automatic send_frame(input logic [7:0] code, input bit bad_parity = 1'b0,
                              input int nbits = 11);
        logic [10:0] frame;
        frame = {1'b1, (~(^code)) ^ bad_parity, code, 1'b0};
        for (int i = 0; i < nbits; i++) begin
            @(posedge CLK);
            ps2_data <= frame[i];
            repeat (half_bit) @(posedge CLK);
            ps2_clk <= 1'b0;
            repeat (half_bit) @(posedge CLK);
            ps2_clk <= 1'b1;
        end
        @(posedge CLK);
        ps2_data <= 1'b1;
        repeat (2 * half_bit) @(posedge CLK);
    endtask

    task automatic send_key(input logic [7:0] code, input bit ext, input bit rel);
        if (ext) begin
            send_frame(ps2_extended_code);
            model_byte(ps2_extended_code, 1'b1);
        end
        if (rel) begin
            send_frame(ps2_release_code);
            model_byte(ps2_release_code, 1'b1);
        end
        send_frame(code);
        model_byte(code, 1'b1);
    endtask

    task automatic pick_code(output logic [7:0] code);
        code = 8'($random(seed));
        while (code == ps2_extended_code || code == ps2_release_code) begin
            code = 8'($random(seed));
        end
    endtask

    task automatic check_events(input string what);
        int         waited;
        key_event_t got;
        key_event_t exp;
        waited = 0;
        while (got_q.size() < exp_q.size() && waited < 200) begin
            @(posedge CLK);
            waited++;
        end
        // leave room for any stray event.
        repeat (20) @(posedge CLK);
        if (got_q.size() != exp_q.size()) begin
            $display("%s: expected %0d events but %0d arrived by time %0t",
                     what, exp_q.size(), got_q.size(), $time);
            err_count++;
        end
        while (got_q.size() > 0 && exp_q.size() > 0) begin
            got = got_q.pop_front();
            exp = exp_q.pop_front();
            compare_event(what, got, exp);
        end
        got_q.delete();
        exp_q.delete();
    endtask

    task automatic end_test(input string name, input int errs_at_start);
        test_count++;
        if (err_count == errs_at_start) begin
            $display("test %-14s passed", name);
        end else begin
            fail_count++;
            $display("test %-14s failed", name);
        end
    endtask

    task automatic test_make_codes();
        int         start;
        logic [7:0] code;
        start = err_count;
        repeat (8) begin
            pick_code(code);
            send_key(code, 1'b0, 1'b0);
        end
        check_events("make codes");
        end_test("make_codes", start);
    endtask

    task automatic test_prefixes();
        int         start;
        logic [7:0] code;
        start = err_count;
        pick_code(code);
        send_key(code, 1'b0, 1'b1);
        pick_code(code);
        send_key(code, 1'b1, 1'b0);
        pick_code(code);
        send_key(code, 1'b1, 1'b1);
        check_events("prefixes");
        end_test("prefixes", start);
    endtask

    task automatic test_parity();
        int                    start;
        logic [7:0]            code;
        logic [reg_data_w-1:0] base;
        logic [reg_data_w-1:0] val;
        start = err_count;
        read_reg(addr_errors, base);
        pick_code(code);
        send_frame(code, 1'b1);
        model_byte(code, 1'b0);
        check_events("parity drop");
        read_reg(addr_errors, val);
        compare_reg("parity count", val, base + 16'd1);
        // the bad frame must cancel the pending E0.
        send_frame(ps2_extended_code);
        model_byte(ps2_extended_code, 1'b1);
        send_frame(code, 1'b1);
        model_byte(code, 1'b0);
        pick_code(code);
        send_frame(code);
        model_byte(code, 1'b1);
        check_events("prefix cleared");
        read_reg(addr_errors, val);
        compare_reg("parity count", val, base + 16'd2);
        end_test("parity", start);
    endtask

    task automatic test_timeout();
        int                    start;
        logic [7:0]            code;
        logic [reg_data_w-1:0] base;
        logic [reg_data_w-1:0] val;
        start = err_count;
        read_reg(addr_errors, base);
        read_reg(addr_timeout, val);
        compare_reg("timeout length", val, reg_data_w'(timeout_reset));
        pick_code(code);
        send_frame(code, 1'b0, 5);
        model_byte(8'h00, 1'b0);
        repeat (stall_cycles) @(posedge CLK);
        read_reg(addr_errors, val);
        compare_reg("framing count", val, base + 16'h0100);
        pick_code(code);
        send_key(code, 1'b0, 1'b0);
        check_events("after timeout");
        write_reg(addr_errors, 16'h0000);
        read_reg(addr_errors, val);
        compare_reg("cleared errors", val, 16'h0000);
        end_test("timeout", start);
    endtask

    task automatic test_backpressure();
        int                    start;
        logic [7:0]            code;
        logic [reg_data_w-1:0] val;
        start = err_count;
        write_reg(addr_overflow, 16'h0000);
        @(posedge CLK);
        event_ready <= 1'b0;
        repeat (6) begin
            pick_code(code);
            send_key(code, 1'b0, 1'b0);
        end
        // only the first four fit in the FIFO.
        void'(exp_q.pop_back());
        void'(exp_q.pop_back());
        read_reg(addr_overflow, val);
        compare_reg("overflow count", val, 16'd2);
        @(posedge CLK);
        event_ready <= 1'b1;
        check_events("backpressure");
        end_test("backpressure", start);
    endtask

    task automatic test_enable();
        int                    start;
        logic [7:0]            code;
        logic [reg_data_w-1:0] base;
        logic [reg_data_w-1:0] val;
        start = err_count;
        write_reg(addr_ctrl, 16'h0000);
        read_reg(addr_ctrl, val);
        compare_reg("ctrl", val, 16'h0000);
        read_reg(addr_errors, base);
        pick_code(code);
        send_frame(code);
        send_frame(code, 1'b1);
        check_events("disabled");
        read_reg(addr_errors, val);
        compare_reg("errors while disabled", val, base);
        write_reg(addr_ctrl, 16'h0001);
        pick_code(code);
        send_key(code, 1'b0, 1'b0);
        check_events("re-enabled");
        end_test("enable", start);
    endtask

    initial begin
        CLK         = 1'b0;
        RESET_N     = 1'b0;
        ps2_clk     = 1'b1;
        ps2_data    = 1'b1;
        reg_addr    = addr_ctrl;
        reg_wdata   = '0;
        reg_write   = 1'b0;
        event_ready = 1'b1;
        repeat (3) @(posedge CLK);
        RESET_N <= 1'b1;
        test_make_codes();
        test_prefixes();
        test_parity();
        test_timeout();
        test_backpressure();
        test_enable();
        $display("%0d tests, %0d failed, %0d errors", test_count, fail_count, err_count);
        if (err_count == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

    initial begin
        #(watchdog_ns);
        $display("simulation timed out after %0d ns", watchdog_ns);
        $display("Something failed");
        $finish;
    end

endmodule

`default_nettype wire

/* ps2_keyboard.f */
hdl/ps2_pkg.sv
hdl/ps2_byte_if.sv
hdl/ps2_frame_rx.sv
hdl/ps2_code_decoder.sv
hdl/key_event_fifo.sv
hdl/ps2_ctrl_regs.sv
hdl/ps2_keyboard_top.sv
tests/tb_ps2_keyboard.sv

/* Bender.yml */
package:
  name: ps2_keyboard

sources:
  - files:
      - hdl/ps2_pkg.sv
      - hdl/ps2_byte_if.sv
      - hdl/ps2_frame_rx.sv
      - hdl/ps2_code_decoder.sv
      - hdl/key_event_fifo.sv
      - hdl/ps2_ctrl_regs.sv
      - hdl/ps2_keyboard_top.sv
  - target: test
    files:
      - tests/tb_ps2_keyboard.sv
